// File: design/cc_pkg.sv
package cc_pkg;

    localparam int CC_DWIDTH    = 32;
    localparam int CC_AWIDTH    = 8;
    localparam int CC_STRB_W    = CC_DWIDTH / 8;
    localparam int CC_PLL_NUM   = 2;
    localparam int CC_CHAIN_LEN = 32;
    localparam int CC_IDX_W     = 3; // word index inside the map

    typedef logic [CC_DWIDTH-1:0] cc_data_t;
    typedef logic [CC_AWIDTH-1:0] cc_addr_t;
    typedef logic [CC_STRB_W-1:0] cc_strb_t;
    typedef logic [CC_IDX_W-1:0]  cc_idx_t;

    // register map, byte addresses
    localparam cc_addr_t ADDR_STATUS     = 8'h00;
    localparam cc_addr_t ADDR_SCRATCH    = 8'h04;
    localparam cc_addr_t ADDR_PLL0_CTRL0 = 8'h08;
    localparam cc_addr_t ADDR_PLL0_CTRL1 = 8'h0C;
    localparam cc_addr_t ADDR_PLL1_CTRL0 = 8'h10;
    localparam cc_addr_t ADDR_PLL1_CTRL1 = 8'h14;
    localparam cc_addr_t ADDR_CHAIN_DATA = 8'h18;
    localparam cc_addr_t ADDR_CHAIN_CTRL = 8'h1C;
    localparam cc_addr_t CC_MAP_END      = 8'h20; // first unmapped byte

    localparam cc_addr_t PLL_CTRL0_ADDR [CC_PLL_NUM] = '{ADDR_PLL0_CTRL0, ADDR_PLL1_CTRL0};
    localparam cc_addr_t PLL_CTRL1_ADDR [CC_PLL_NUM] = '{ADDR_PLL0_CTRL1, ADDR_PLL1_CTRL1};

    localparam logic [5:0] PLL_REFDIV_RST  = 6'd1;
    localparam cc_data_t   PLL_CTRL0_RST   = cc_data_t'(PLL_REFDIV_RST) << 8;
    localparam cc_data_t   PLL_CTRL0_MASK  = 32'h0FFF_3FFF; // 31:28 and 15:14 reserved
    localparam cc_data_t   PLL_CTRL1_MASK  = 32'hFFFF_FFFF;
    localparam cc_data_t   CHAIN_CTRL_MASK = 32'h0000_0003;

    typedef struct packed {
        cc_addr_t paddr;
        logic     psel;
        logic     penable;
        logic     pwrite;
        cc_data_t pwdata;
        cc_strb_t pstrb;
    } apb_req_t;

    typedef struct packed {
        cc_data_t prdata;
        logic     pready;
        logic     pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic     rd;
        logic     wr;
        cc_idx_t  idx;
        cc_data_t wdata;
        cc_strb_t wstrb;
    } reg_req_t;

    typedef struct packed {
        logic     ack;
        logic     err;
        cc_data_t rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic        pllen;
        logic        dsmen;
        logic        dacen;
        logic        foutvcoen;
        logic [3:0]  fouten;
        logic [5:0]  refdiv;
        logic [11:0] fbdiv;
        logic [23:0] frac;
        logic [3:0]  postdiv0;
        logic [3:0]  postdiv1;
    } pll_ctrl_t;

    typedef struct packed {
        logic clk;
        logic data;
        logic cmd;
    } ccff_out_t;

    typedef enum logic [1:0] {
        IDLE,
        LOW,
        HIGH
    } chain_state_e;

    function automatic cc_idx_t reg_idx(cc_addr_t addr);
        return addr[CC_IDX_W+1:2];
    endfunction

    // byte lanes with strobe set take the new data
    function automatic cc_data_t apply_strb(cc_data_t old, cc_data_t wdata, cc_strb_t strb);
        cc_data_t res;
        res = old;
        for (int b = 0; b < CC_STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: design/cc_apb_regif.sv
`timescale 1ns/1ps
module cc_apb_regif (
    input  logic             clk          ,
    input  logic             rst_n_i      ,
    input  cc_pkg::apb_req_t apb_req_i    ,
    output cc_pkg::apb_rsp_t apb_rsp_o    ,
    output cc_pkg::reg_req_t status_req_o ,
    output cc_pkg::reg_req_t pll_req_o    ,
    output cc_pkg::reg_req_t chain_req_o  ,
    input  cc_pkg::reg_rsp_t status_rsp_i ,
    input  cc_pkg::reg_rsp_t pll_rsp_i    ,
    input  cc_pkg::reg_rsp_t chain_rsp_i
);
    import cc_pkg::*;

    logic     access;
    logic     in_map;
    cc_idx_t  idx;
    logic     sel_status;
    logic     sel_pll;
    logic     sel_chain;
    reg_req_t req_base;
    reg_rsp_t sel_rsp;

    assign access = apb_req_i.psel && apb_req_i.penable;
    assign in_map = apb_req_i.paddr < CC_MAP_END;
    assign idx    = reg_idx(apb_req_i.paddr);

    assign sel_status = in_map && (idx == reg_idx(ADDR_STATUS) ||
                                   idx == reg_idx(ADDR_SCRATCH) ||
                                   idx == reg_idx(ADDR_CHAIN_CTRL));
    assign sel_pll    = in_map && idx >= reg_idx(ADDR_PLL0_CTRL0) &&
                                  idx <= reg_idx(ADDR_PLL1_CTRL1);
    assign sel_chain  = in_map && idx == reg_idx(ADDR_CHAIN_DATA);

    always_comb begin
        req_base       = '0;
        req_base.idx   = idx;
        req_base.wdata = apb_req_i.pwdata;
        req_base.wstrb = apb_req_i.pstrb;

        status_req_o    = req_base;
        status_req_o.rd = access && !apb_req_i.pwrite && sel_status;
        status_req_o.wr = access && apb_req_i.pwrite && sel_status;

        pll_req_o    = req_base;
        pll_req_o.rd = access && !apb_req_i.pwrite && sel_pll;
        pll_req_o.wr = access && apb_req_i.pwrite && sel_pll;

        chain_req_o    = req_base;
        chain_req_o.rd = access && !apb_req_i.pwrite && sel_chain;
        chain_req_o.wr = access && apb_req_i.pwrite && sel_chain;
    end

    always_comb begin
        if (sel_status) begin
            sel_rsp = status_rsp_i;
        end else if (sel_pll) begin
            sel_rsp = pll_rsp_i;
        end else if (sel_chain) begin
            sel_rsp = chain_rsp_i;
        end else begin
            sel_rsp       = '0; // nobody owns it, answer with an error
            sel_rsp.ack   = access;
            sel_rsp.err   = 1'b1;
        end
        apb_rsp_o.pready  = sel_rsp.ack;
        apb_rsp_o.pslverr = sel_rsp.ack && sel_rsp.err;
        apb_rsp_o.prdata  = sel_rsp.rdata;
    end

    a_pready_in_access : assert property (@(posedge clk) disable iff (!rst_n_i)
        apb_rsp_o.pready |-> apb_req_i.psel && apb_req_i.penable);

    a_one_block : assert property (@(posedge clk) disable iff (!rst_n_i)
        access && in_map |-> $onehot({status_req_o.rd || status_req_o.wr,
                                      pll_req_o.rd || pll_req_o.wr,
                                      chain_req_o.rd || chain_req_o.wr}));

endmodule

// File: design/cc_status_regs.sv
`timescale 1ns/1ps
module cc_status_regs (
    input  logic                          clk           ,
    input  logic                          rst_n_i       ,
    input  cc_pkg::reg_req_t              req_i         ,
    output cc_pkg::reg_rsp_t              rsp_o         ,
    input  logic [cc_pkg::CC_PLL_NUM-1:0] pll_lock_i    ,
    input  logic                          chain_busy_i  ,
    output logic                          chain_rst_n_o ,
    output logic                          cfg_done_o
);
    import cc_pkg::*;

    cc_data_t scratch_q;
    cc_data_t chain_ctrl_q;
    cc_data_t status;
    logic     status_wr;

    assign status = {{(CC_DWIDTH-CC_PLL_NUM-2){1'b0}}, pll_lock_i, chain_busy_i,
                     chain_ctrl_q[0]};
    assign status_wr = req_i.wr && req_i.idx == reg_idx(ADDR_STATUS);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scratch_q    <= '0;
            chain_ctrl_q <= '0;
        end else if (req_i.wr) begin
            if (req_i.idx == reg_idx(ADDR_SCRATCH)) begin
                scratch_q <= apply_strb(scratch_q, req_i.wdata, req_i.wstrb);
            end
            if (req_i.idx == reg_idx(ADDR_CHAIN_CTRL)) begin
                chain_ctrl_q <= apply_strb(chain_ctrl_q, req_i.wdata, req_i.wstrb) &
                                CHAIN_CTRL_MASK;
            end
        end
    end

    always_comb begin
        rsp_o.ack   = req_i.rd || req_i.wr;
        rsp_o.err   = status_wr; // STATUS is read only
        rsp_o.rdata = '0;
        case (req_i.idx)
            reg_idx(ADDR_STATUS)     : rsp_o.rdata = status;
            reg_idx(ADDR_SCRATCH)    : rsp_o.rdata = scratch_q;
            reg_idx(ADDR_CHAIN_CTRL) : rsp_o.rdata = chain_ctrl_q;
            default                  : rsp_o.rdata = '0;
        endcase
    end

    assign chain_rst_n_o = chain_ctrl_q[1];
    assign cfg_done_o    = chain_ctrl_q[0] && (&pll_lock_i); // done needs every lock

    a_status_ro : assert property (@(posedge clk) disable iff (!rst_n_i)
        status_wr |-> rsp_o.err ##1 ($stable(scratch_q) && $stable(chain_ctrl_q)));

endmodule

// File: design/cc_pll_regs.sv
`timescale 1ns/1ps
module cc_pll_regs (
    input  logic              clk                           ,
    input  logic              rst_n_i                       ,
    input  cc_pkg::reg_req_t  req_i                         ,
    output cc_pkg::reg_rsp_t  rsp_o                         ,
    output cc_pkg::pll_ctrl_t pll_ctrl_o [cc_pkg::CC_PLL_NUM]
);
    import cc_pkg::*;

    cc_data_t ctrl0_q [CC_PLL_NUM];
    cc_data_t ctrl1_q [CC_PLL_NUM];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int p = 0; p < CC_PLL_NUM; p++) begin
                ctrl0_q[p] <= PLL_CTRL0_RST; // refdiv comes up as 1
                ctrl1_q[p] <= '0;
            end
        end else if (req_i.wr) begin
            for (int p = 0; p < CC_PLL_NUM; p++) begin
                if (req_i.idx == reg_idx(PLL_CTRL0_ADDR[p])) begin
                    ctrl0_q[p] <= apply_strb(ctrl0_q[p], req_i.wdata, req_i.wstrb) &
                                  PLL_CTRL0_MASK;
                end
                if (req_i.idx == reg_idx(PLL_CTRL1_ADDR[p])) begin
                    ctrl1_q[p] <= apply_strb(ctrl1_q[p], req_i.wdata, req_i.wstrb) &
                                  PLL_CTRL1_MASK;
                end
            end
        end
    end

    // reserved bits never get stored, so readback is the raw register
    always_comb begin
        rsp_o.ack   = req_i.rd || req_i.wr;
        rsp_o.err   = 1'b0;
        rsp_o.rdata = '0;
        for (int p = 0; p < CC_PLL_NUM; p++) begin
            if (req_i.idx == reg_idx(PLL_CTRL0_ADDR[p])) begin
                rsp_o.rdata = ctrl0_q[p];
            end
            if (req_i.idx == reg_idx(PLL_CTRL1_ADDR[p])) begin
                rsp_o.rdata = ctrl1_q[p];
            end
        end
    end

    genvar p;
    generate
        for (p = 0; p < CC_PLL_NUM; p++) begin : g_pll
            assign pll_ctrl_o[p].pllen     = ctrl0_q[p][0];
            assign pll_ctrl_o[p].dsmen     = ctrl0_q[p][1];
            assign pll_ctrl_o[p].dacen     = ctrl0_q[p][2];
            assign pll_ctrl_o[p].foutvcoen = ctrl0_q[p][3];
            assign pll_ctrl_o[p].fouten    = ctrl0_q[p][7:4];
            assign pll_ctrl_o[p].refdiv    = ctrl0_q[p][13:8];
            assign pll_ctrl_o[p].fbdiv     = ctrl0_q[p][27:16];
            assign pll_ctrl_o[p].frac      = ctrl1_q[p][23:0];
            assign pll_ctrl_o[p].postdiv0  = ctrl1_q[p][27:24];
            assign pll_ctrl_o[p].postdiv1  = ctrl1_q[p][31:28];
        end
    endgenerate

endmodule

// File: design/cc_chain_shifter.sv
`timescale 1ns/1ps
module cc_chain_shifter (
    input  logic              clk        ,
    input  logic              rst_n_i    ,
    input  cc_pkg::reg_req_t  req_i      ,
    output cc_pkg::reg_rsp_t  rsp_o      ,
    output cc_pkg::ccff_out_t fcb_o      ,
    input  logic              fcb_data_i ,
    output logic              busy_o
);
    import cc_pkg::*;

    localparam int CNT_W = $clog2(CC_CHAIN_LEN);

    chain_state_e            state_q;
    logic [CNT_W-1:0]        bit_cnt_q;
    logic [CC_CHAIN_LEN-1:0] shift_q;
    logic [CC_CHAIN_LEN-1:0] cap_q;
    logic                    accept;
    logic                    last_bit;

    assign accept   = req_i.wr && state_q == IDLE; // new word only when idle
    assign last_bit = bit_cnt_q == CNT_W'(CC_CHAIN_LEN - 1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q   <= LOW;
                        bit_cnt_q <= '0;
                    end
                end
                LOW: begin
                    state_q <= HIGH;
                end
                HIGH: begin
                    if (last_bit) begin
                        state_q <= IDLE;
                    end else begin
                        state_q   <= LOW;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= CC_CHAIN_LEN'(req_i.wdata);
        end else if (state_q == HIGH) begin
            shift_q <= shift_q << 1; // msb first
        end
    end

    // sampled on the edge where the chain clock rises
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cap_q <= '0;
        end else if (state_q == LOW) begin
            cap_q <= {cap_q[CC_CHAIN_LEN-2:0], fcb_data_i};
        end
    end

    assign busy_o     = state_q != IDLE;
    assign fcb_o.cmd  = busy_o;
    assign fcb_o.clk  = state_q == HIGH;
    assign fcb_o.data = busy_o && shift_q[CC_CHAIN_LEN-1];

    always_comb begin
        rsp_o.ack   = req_i.rd || accept; // writes wait while busy
        rsp_o.err   = 1'b0;
        rsp_o.rdata = CC_DWIDTH'(cap_q);
    end

    a_cmd_start : assert property (@(posedge clk) disable iff (!rst_n_i)
        accept |=> fcb_o.cmd && !fcb_o.clk);

    a_cmd_end : assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(fcb_o.cmd) |-> $past(state_q == HIGH && last_bit));

endmodule

// File: design/config_controller.sv
`timescale 1ns/1ps
module config_controller (
    input  logic                          clk                            ,
    input  logic                          rst_n_i                        ,
    // apb
    input  cc_pkg::apb_req_t              apb_req_i                      ,
    output cc_pkg::apb_rsp_t              apb_rsp_o                      ,
    // pll
    output cc_pkg::pll_ctrl_t             pll_ctrl_o [cc_pkg::CC_PLL_NUM],
    input  logic [cc_pkg::CC_PLL_NUM-1:0] pll_lock_i                     ,
    // fcb
    output cc_pkg::ccff_out_t             fcb_o                          ,
    input  logic                          fcb_data_i                     ,
    output logic                          fcb_rst_n_o                    ,
    output logic                          cfg_done_o
);
    import cc_pkg::*;

    reg_req_t status_req;
    reg_req_t pll_req;
    reg_req_t chain_req;
    reg_rsp_t status_rsp;
    reg_rsp_t pll_rsp;
    reg_rsp_t chain_rsp;
    logic     chain_busy;

    cc_apb_regif regif_u (
        .clk          (clk       ),
        .rst_n_i      (rst_n_i   ),
        .apb_req_i    (apb_req_i ),
        .apb_rsp_o    (apb_rsp_o ),
        .status_req_o (status_req),
        .pll_req_o    (pll_req   ),
        .chain_req_o  (chain_req ),
        .status_rsp_i (status_rsp),
        .pll_rsp_i    (pll_rsp   ),
        .chain_rsp_i  (chain_rsp )
    );

    cc_status_regs status_u (
        .clk           (clk        ),
        .rst_n_i       (rst_n_i    ),
        .req_i         (status_req ),
        .rsp_o         (status_rsp ),
        .pll_lock_i    (pll_lock_i ),
        .chain_busy_i  (chain_busy ),
        .chain_rst_n_o (fcb_rst_n_o),
        .cfg_done_o    (cfg_done_o )
    );

    cc_pll_regs pll_u (
        .clk        (clk       ),
        .rst_n_i    (rst_n_i   ),
        .req_i      (pll_req   ),
        .rsp_o      (pll_rsp   ),
        .pll_ctrl_o (pll_ctrl_o)
    );

    cc_chain_shifter chain_u (
        .clk        (clk       ),
        .rst_n_i    (rst_n_i   ),
        .req_i      (chain_req ),
        .rsp_o      (chain_rsp ),
        .fcb_o      (fcb_o     ),
        .fcb_data_i (fcb_data_i),
        .busy_o     (chain_busy)
    );

endmodule

// File: dv/tb_clkgen.sv
`timescale 1ns/1ps
module tb_clkgen (
    output logic clk_o   ,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o; // 40 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: dv/config_controller_tb.sv
`timescale 1ns/1ps
module config_controller_tb;
    import cc_pkg::*;

    // tests need about 500 cycles, mostly in the two chain words
    localparam int TIMEOUT_CYCLES = 4000;

    logic                    clk;
    logic                    rst_n;
    apb_req_t                apb_req = '0;
    apb_rsp_t                apb_rsp;
    pll_ctrl_t               pll_ctrl [CC_PLL_NUM];
    logic [CC_PLL_NUM-1:0]   pll_lock = '0;
    ccff_out_t               fcb;
    logic                    fcb_rst_n;
    logic                    cfg_done;
    logic                    chain_clk;
    logic [CC_CHAIN_LEN-1:0] chain_model = '0; // external chain, one word deep
    int                      seed = 15;
    int                      errors = 0;
    int                      cycles = 0;
    cc_data_t                shadow [8];
    string                   name_q [$];
    logic [63:0]             exp_q [$];
    logic [63:0]             act_q [$];

    tb_clkgen clkgen_u (
        .clk_o   (clk  ),
        .rst_n_o (rst_n)
    );

    config_controller DUT (
        .clk         (clk                          ),
        .rst_n_i     (rst_n                        ),
        .apb_req_i   (apb_req                      ),
        .apb_rsp_o   (apb_rsp                      ),
        .pll_ctrl_o  (pll_ctrl                     ),
        .pll_lock_i  (pll_lock                     ),
        .fcb_o       (fcb                          ),
        .fcb_data_i  (chain_model[CC_CHAIN_LEN-1]  ),
        .fcb_rst_n_o (fcb_rst_n                    ),
        .cfg_done_o  (cfg_done                     )
    );

    assign chain_clk = fcb.clk;

    always @(posedge chain_clk) begin
        chain_model <= {chain_model[CC_CHAIN_LEN-2:0], fcb.data};
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // expected readback: strobed byte lanes, then reserved bits cleared
    function automatic cc_data_t exp_reg(cc_addr_t addr, cc_data_t old, cc_data_t wdata,
                                         cc_strb_t strb);
        cc_data_t res;
        cc_data_t mask;
        case (addr)
            ADDR_PLL0_CTRL0, ADDR_PLL1_CTRL0 : mask = 32'h0FFF_3FFF;
            ADDR_CHAIN_CTRL                  : mask = 32'h0000_0003;
            default                          : mask = 32'hFFFF_FFFF;
        endcase
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res & mask;
    endfunction

    function automatic pll_ctrl_t pll_fields(cc_data_t c0, cc_data_t c1);
        pll_ctrl_t f;
        f.pllen     = c0[0];
        f.dsmen     = c0[1];
        f.dacen     = c0[2];
        f.foutvcoen = c0[3];
        f.fouten    = c0[7:4];
        f.refdiv    = c0[13:8];
        f.fbdiv     = c0[27:16];
        f.frac      = c1[23:0];
        f.postdiv0  = c1[27:24];
        f.postdiv1  = c1[31:28];
        return f;
    endfunction

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic expect_eq(string name, logic [63:0] exp, logic [63:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    always @(posedge clk) begin
        while (exp_q.size() > 0) begin
            check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
        end
    end

    task automatic apb_transfer(input logic wr, input cc_addr_t addr, input cc_data_t wdata,
                                input cc_strb_t strb, output cc_data_t rdata,
                                output logic err, output int waits);
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.pwdata  <= wdata;
        apb_req.pstrb   <= strb;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk); // access ends here
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_write(input cc_addr_t addr, input cc_data_t wdata, input cc_strb_t strb,
                             output logic err, output int waits);
        cc_data_t unused;
        apb_transfer(1'b1, addr, wdata, strb, unused, err, waits);
    endtask

    task automatic apb_read(input cc_addr_t addr, output cc_data_t rdata, output logic err);
        int waits;
        apb_transfer(1'b0, addr, '0, '0, rdata, err, waits);
    endtask

    task automatic read_check(string name, cc_addr_t addr, cc_data_t exp);
        cc_data_t rdata;
        logic     err;
        apb_read(addr, rdata, err);
        expect_eq(name, 64'(exp), 64'(rdata));
        expect_eq({name, " pslverr"}, 64'(0), 64'(err));
    endtask

    task automatic write_check(string name, cc_addr_t addr, cc_data_t wdata, cc_strb_t strb,
                               logic exp_err);
        logic err;
        int   waits;
        apb_write(addr, wdata, strb, err, waits);
        expect_eq({name, " pslverr"}, 64'(exp_err), 64'(err));
    endtask

    task automatic reset_values();
        for (int i = 0; i < 8; i++) begin
            shadow[i] = '0;
        end
        shadow[2] = 32'h0000_0100; // refdiv comes up as 1
        shadow[4] = 32'h0000_0100;
        @(posedge rst_n);
        @(negedge clk);
        expect_eq("reset pready", 64'(0), 64'(apb_rsp.pready));
        expect_eq("reset pslverr", 64'(0), 64'(apb_rsp.pslverr));
        expect_eq("reset fcb", 64'(0), 64'(fcb));
        expect_eq("reset fcb_rst_n", 64'(0), 64'(fcb_rst_n));
        expect_eq("reset cfg_done", 64'(0), 64'(cfg_done));
        for (int p = 0; p < CC_PLL_NUM; p++) begin
            expect_eq($sformatf("reset pll%0d", p), 64'(pll_fields(32'h100, '0)),
                      64'(pll_ctrl[p]));
        end
        for (int a = 0; a < 8; a++) begin
            read_check($sformatf("reset read %02h", 4 * a), cc_addr_t'(4 * a), shadow[a]);
        end
    endtask

    task automatic pll_register_access();
        cc_addr_t    addr;
        cc_data_t    wdata;
        logic [31:0] r;
        for (int round = 0; round < 8; round++) begin
            for (int k = 0; k < 4; k++) begin
                addr  = ADDR_PLL0_CTRL0 + cc_addr_t'(4 * k);
                wdata = $random(seed);
                r     = $random(seed);
                write_check($sformatf("pll write %02h", addr), addr, wdata, r[3:0], 1'b0);
                shadow[addr[4:2]] = exp_reg(addr, shadow[addr[4:2]], wdata, r[3:0]);
                read_check($sformatf("pll readback %02h", addr), addr, shadow[addr[4:2]]);
            end
        end
        @(negedge clk);
        for (int p = 0; p < CC_PLL_NUM; p++) begin
            expect_eq($sformatf("pll%0d fields", p),
                      64'(pll_fields(shadow[2 + 2*p], shadow[3 + 2*p])), 64'(pll_ctrl[p]));
        end
    endtask

    task automatic error_responses();
        cc_addr_t    bad [3];
        cc_data_t    rdata;
        cc_data_t    wdata;
        logic [31:0] r;
        logic        err;
        r      = $random(seed);
        bad[0] = 8'h20;
        bad[1] = 8'h20 + (r[7:0] % 8'd224); // anywhere above the map
        bad[2] = 8'hFC;
        for (int i = 0; i < 3; i++) begin
            apb_read(bad[i], rdata, err);
            expect_eq($sformatf("read unmapped %02h", bad[i]), 64'(1), 64'(err));
            write_check($sformatf("write unmapped %02h", bad[i]), bad[i], r, 4'hF, 1'b1);
        end
        write_check("status write", ADDR_STATUS, 32'hFFFF_FFFF, 4'hF, 1'b1);
        read_check("status unchanged", ADDR_STATUS, shadow[0]);
        wdata = $random(seed);
        write_check("scratch write", ADDR_SCRATCH, wdata, 4'hF, 1'b0);
        shadow[1] = exp_reg(ADDR_SCRATCH, shadow[1], wdata, 4'hF);
        read_check("scratch readback", ADDR_SCRATCH, shadow[1]);
    endtask

    task automatic chain_transfer();
        cc_data_t w1;
        cc_data_t w2;
        cc_data_t rdata;
        logic     err;
        int       waits;
        w1 = $random(seed);
        w2 = $random(seed);
        apb_write(ADDR_CHAIN_DATA, w1, 4'hF, err, waits);
        expect_eq("chain first word waits", 64'(0), 64'(waits));
        apb_write(ADDR_CHAIN_DATA, w2, 4'hF, err, waits);
        expect_eq("chain second word stalled", 64'(1), 64'(waits > 0));
        expect_eq("chain second word pslverr", 64'(0), 64'(err));
        apb_read(ADDR_STATUS, rdata, err);
        expect_eq("chain busy after push", 64'(1), 64'(rdata[1]));
        while (rdata[1]) begin
            apb_read(ADDR_STATUS, rdata, err);
        end
        @(negedge clk);
        expect_eq("chain cmd when idle", 64'(0), 64'(fcb.cmd));
        shadow[6] = w1; // external chain returns the previous word
        read_check("chain capture", ADDR_CHAIN_DATA, shadow[6]);
    endtask

    task automatic cfg_done_combinations();
        cc_data_t    wdata;
        logic [31:0] r;
        logic [1:0]  locks;
        for (int c = 0; c < 8; c++) begin
            locks = c[2:1];
            r     = $random(seed);
            wdata = {r[31:2], c[2] ^ c[0], c[0]};
            @(posedge clk);
            pll_lock <= locks;
            write_check($sformatf("chain ctrl write %0d", c), ADDR_CHAIN_CTRL, wdata, 4'hF, 1'b0);
            shadow[7] = exp_reg(ADDR_CHAIN_CTRL, shadow[7], wdata, 4'hF);
            @(negedge clk);
            expect_eq($sformatf("cfg_done %0d", c), 64'(shadow[7][0] && locks == 2'b11),
                      64'(cfg_done));
            expect_eq($sformatf("fcb_rst_n %0d", c), 64'(shadow[7][1]), 64'(fcb_rst_n));
            read_check($sformatf("status locks %0d", c), ADDR_STATUS,
                       {28'h0, locks, 1'b0, shadow[7][0]});
            read_check($sformatf("chain ctrl readback %0d", c), ADDR_CHAIN_CTRL, shadow[7]);
        end
    endtask

    initial begin
        reset_values();
        pll_register_access();
        error_responses();
        chain_transfer();
        cfg_done_combinations();
        repeat (2) @(posedge clk);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "checks did not complete cleanly");
        end
    end

endmodule

// File: config_controller.f
design/cc_pkg.sv
design/cc_apb_regif.sv
design/cc_status_regs.sv
design/cc_pll_regs.sv
design/cc_chain_shifter.sv
design/config_controller.sv
dv/tb_clkgen.sv
dv/config_controller_tb.sv

// File: Makefile
TOP  := config_controller_tb
SRCS := $(shell cat config_controller.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

obj_dir/V$(TOP): config_controller.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f config_controller.f

clean:
	rm -rf obj_dir
